/* Makefile */
# Verilator simulation of the scan doubler chain

TOP = tb_video_scan2x

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* src.f */
src/video_pkg.sv
src/pixel_bw_filter.sv
src/line_buffer.sv
src/scan2x_out.sv
src/video_scan2x_top.sv
verif/tb_clk_gen.sv
verif/tb_video_scan2x.sv

/* src/line_buffer.sv */
/*
    Two-bank line buffer
    One bank collects the incoming line while the other one is read back by
    the scan doubler. Banks swap on the rising edge of hs
*/
module line_buffer #(
    parameter int HLEN = 384
) (
    input  logic                    clk_sys,
    input  logic                    arst_n,
    input  video_pkg::pixel_t       pix,
    input  logic                    pix_stb,
    input  logic [$clog2(HLEN)-1:0] rd_addr,
    output video_pkg::rgb_t         rd_data,
    output logic                    line_stb
);

    localparam int            AW   = $clog2(HLEN);
    localparam logic [AW-1:0] LAST = AW'(HLEN - 1);

    video_pkg::rgb_t mem [0:1][0:HLEN-1];

    logic [AW-1:0] wr_addr;
    logic          wr_bank;
    logic          hs_last;
    logic          line_start;
    logic [AW-1:0] wa;
    logic          wb;

    // A new line writes its first pixel at address 0 of the other bank
    always_comb begin
        line_start = pix_stb && pix.hs && !hs_last;
        wa         = line_start ? '0 : wr_addr;
        wb         = line_start ? ~wr_bank : wr_bank;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr  <= '0;
            wr_bank  <= 1'b0;
            hs_last  <= 1'b0;
            line_stb <= 1'b0;
        end else begin
            line_stb <= line_start;
            if (pix_stb) begin
                hs_last <= pix.hs;
                wr_bank <= wb;
                // Hold at the last word if the line runs long
                wr_addr <= (wa == LAST) ? wa : wa + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pix_stb) begin
            mem[wb][wa] <= pix.rgb;
        end
        rd_data <= mem[~wr_bank][rd_addr];
    end

    wr_addr_range: assert property (
        @(posedge clk_sys) disable iff (!arst_n) wr_addr <= LAST
    );

endmodule

/* src/pixel_bw_filter.sv */
/*
    Bandwidth filter
    Samples game video at the pixel enable. With bw_en set each channel is the
    sum of the pixel and the one before it, otherwise the pixel is doubled so
    that both modes share the same scale
*/
module pixel_bw_filter (
    input  logic                         clk_sys,
    input  logic                         arst_n,
    input  logic                         pxl_cen,
    input  logic                         bw_en,
    input  logic [video_pkg::COLORW-1:0] game_r,
    input  logic [video_pkg::COLORW-1:0] game_g,
    input  logic [video_pkg::COLORW-1:0] game_b,
    input  logic                         hs,
    input  logic                         vs,
    input  logic                         lhbl,
    input  logic                         lvbl,
    output video_pkg::pixel_t            pix,
    output logic                         pix_stb
);

    // Last sampled game colour
    logic [video_pkg::COLORW-1:0] prev_r;
    logic [video_pkg::COLORW-1:0] prev_g;
    logic [video_pkg::COLORW-1:0] prev_b;
    video_pkg::rgb_t              sum_rgb;

    function automatic video_pkg::color_t chan_sum(
        input logic [video_pkg::COLORW-1:0] cur,
        input logic [video_pkg::COLORW-1:0] prv,
        input logic                         en
    );
        video_pkg::color_t a;
        video_pkg::color_t b;
        a = video_pkg::color_t'(cur);
        b = en ? video_pkg::color_t'(prv) : a;
        return a + b;
    endfunction

    always_comb begin
        sum_rgb.r = chan_sum(game_r, prev_r, bw_en);
        sum_rgb.g = chan_sum(game_g, prev_g, bw_en);
        sum_rgb.b = chan_sum(game_b, prev_b, bw_en);
    end

    // Colour and sync move together, one clock behind pxl_cen
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            prev_r  <= game_r;
            prev_g  <= game_g;
            prev_b  <= game_b;
            pix.rgb <= sum_rgb;
            pix.hs  <= hs;
            pix.vs  <= vs;
            pix.hb  <= lhbl;
            pix.vb  <= lvbl;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pix_stb <= 1'b0;
        end else begin
            pix_stb <= pxl_cen;
        end
    end

endmodule

/* src/scan2x_out.sv */
/*
    Scan doubler output stage
    Reads the stored line twice at the doubled pixel enable, dims the second
    copy by the scanline mode and expands each channel to 8 bits
*/
module scan2x_out #(
    parameter int HLEN = 384,
    parameter int HSW  = 4
) (
    input  logic                    clk_sys,
    input  logic                    arst_n,
    input  logic                    pxl2_cen,
    input  video_pkg::sl_mode_e     sl_mode,
    input  logic                    line_stb,
    input  video_pkg::rgb_t         rd_data,
    output logic [$clog2(HLEN)-1:0] rd_addr,
    output video_pkg::rgb8_t        out_rgb,
    output logic                    out_hs,
    output logic                    out_de,
    output logic                    out_cen
);

    localparam int            AW       = $clog2(HLEN);
    localparam logic [AW-1:0] LAST     = AW'(HLEN - 1);
    localparam logic [AW-1:0] SYNC_END = AW'(HSW);

    logic [AW-1:0]   rd_cnt;
    logic            pass2;
    logic            active;
    logic            pass_now;
    logic            act_now;
    logic            s1_cen;
    logic            s1_hs;
    logic            s1_de;
    logic            s1_pass2;
    video_pkg::rgb_t dim_rgb;

    function automatic video_pkg::color_t dim(
        input video_pkg::color_t   v,
        input video_pkg::sl_mode_e mode
    );
        case (mode)
            video_pkg::SL_25: return v - (v >> 2);
            video_pkg::SL_50: return v >> 1;
            video_pkg::SL_75: return v >> 2;
            default:          return v;
        endcase
    endfunction

    // line_stb restarts the pass in the same cycle
    always_comb begin
        rd_addr  = line_stb ? '0 : rd_cnt;
        pass_now = line_stb ? 1'b0 : pass2;
        act_now  = active | line_stb;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rd_cnt   <= '0;
            pass2    <= 1'b0;
            active   <= 1'b0;
            s1_cen   <= 1'b0;
            s1_hs    <= 1'b0;
            s1_de    <= 1'b0;
            s1_pass2 <= 1'b0;
        end else begin
            if (line_stb) begin
                active <= 1'b1;
            end
            if (pxl2_cen) begin
                rd_cnt <= (rd_addr == LAST) ? '0 : rd_addr + 1'b1;
                pass2  <= pass_now | (rd_addr == LAST);
            end else if (line_stb) begin
                rd_cnt <= '0;
                pass2  <= 1'b0;
            end
            // Read issued, data comes back next cycle
            s1_cen <= pxl2_cen;
            if (pxl2_cen) begin
                s1_hs    <= act_now && (rd_addr < SYNC_END);
                s1_de    <= act_now && (rd_addr >= SYNC_END);
                s1_pass2 <= pass_now;
            end
        end
    end

    always_comb begin
        dim_rgb = rd_data;
        if (s1_pass2) begin
            dim_rgb.r = dim(rd_data.r, sl_mode);
            dim_rgb.g = dim(rd_data.g, sl_mode);
            dim_rgb.b = dim(rd_data.b, sl_mode);
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            out_cen <= 1'b0;
            out_hs  <= 1'b0;
            out_de  <= 1'b0;
            out_rgb <= '0;
        end else begin
            out_cen <= s1_cen;
            if (s1_cen) begin
                out_hs    <= s1_hs;
                out_de    <= s1_de;
                // Black outside the active part
                out_rgb.r <= s1_de ? video_pkg::extend8(dim_rgb.r) : 8'd0;
                out_rgb.g <= s1_de ? video_pkg::extend8(dim_rgb.g) : 8'd0;
                out_rgb.b <= s1_de ? video_pkg::extend8(dim_rgb.b) : 8'd0;
            end
        end
    end

    hs_de_excl: assert property (
        @(posedge clk_sys) disable iff (!arst_n) !(out_hs && out_de)
    );

endmodule

/* src/video_pkg.sv */
/*
    Video path definitions
    Colour widths, pixel bundles, scanline modes and the 8-bit colour
    expansion used by the scan doubler
*/
package video_pkg;

    // Game colour depth per channel
    parameter int COLORW  = 4;
    // One extra bit for the two-pixel sum
    parameter int CLROUTW = COLORW + 1;

    typedef logic [CLROUTW-1:0] color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // hb and vb are the game blanking flags, active low
    typedef struct packed {
        rgb_t rgb;
        logic hs;
        logic vs;
        logic hb;
        logic vb;
    } pixel_t;

    // Dimming applied to the second copy of a line
    typedef enum logic [1:0] {
        SL_NONE = 2'd0,
        SL_25   = 2'd1,
        SL_50   = 2'd2,
        SL_75   = 2'd3
    } sl_mode_e;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    // Top bits of the channel repeat into the low end
    function automatic logic [7:0] extend8(input color_t a);
        logic [4*CLROUTW-1:0] rep;
        rep = {4{a}};
        return rep[4*CLROUTW-1 -: 8];
    endfunction

endpackage

/* src/video_scan2x_top.sv */
/*
    Video output path
    Bandwidth filter, line buffer and scan doubler in a single chain
*/
module video_scan2x_top #(
    parameter int COLORW = 4,
    parameter int HLEN   = 384,
    parameter int HSW    = 4
) (
    input  logic                clk_sys,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                pxl2_cen,
    input  logic                bw_en,
    input  video_pkg::sl_mode_e sl_mode,
    input  logic [COLORW-1:0]   game_r,
    input  logic [COLORW-1:0]   game_g,
    input  logic [COLORW-1:0]   game_b,
    input  logic                hs,
    input  logic                vs,
    input  logic                lhbl,
    input  logic                lvbl,
    output video_pkg::rgb8_t    scan2x_rgb,
    output logic                scan2x_hs,
    output logic                scan2x_de,
    output logic                scan2x_cen
);

    video_pkg::pixel_t       pix;
    logic                    pix_stb;
    logic                    line_stb;
    logic [$clog2(HLEN)-1:0] rd_addr;
    video_pkg::rgb_t         rd_data;

    pixel_bw_filter u_filter (
        .clk_sys  ( clk_sys  ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .bw_en    ( bw_en    ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .pix      ( pix      ),
        .pix_stb  ( pix_stb  )
    );

    line_buffer #(.HLEN(HLEN)) u_linebuf (
        .clk_sys  ( clk_sys  ),
        .arst_n   ( arst_n   ),
        .pix      ( pix      ),
        .pix_stb  ( pix_stb  ),
        .rd_addr  ( rd_addr  ),
        .rd_data  ( rd_data  ),
        .line_stb ( line_stb )
    );

    scan2x_out #(.HLEN(HLEN), .HSW(HSW)) u_scan2x (
        .clk_sys  ( clk_sys    ),
        .arst_n   ( arst_n     ),
        .pxl2_cen ( pxl2_cen   ),
        .sl_mode  ( sl_mode    ),
        .line_stb ( line_stb   ),
        .rd_data  ( rd_data    ),
        .rd_addr  ( rd_addr    ),
        .out_rgb  ( scan2x_rgb ),
        .out_hs   ( scan2x_hs  ),
        .out_de   ( scan2x_de  ),
        .out_cen  ( scan2x_cen )
    );

endmodule

/* verif/tb_clk_gen.sv */
/*
    Testbench clock and reset
    Free running clock of period 10 and an active low reset held for 5 cycles
*/
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release just after a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* verif/tb_video_scan2x.sv */
/*
    Testbench for the scan doubler chain
    Drives game lines under a table of filter and scanline settings, rebuilds
    each doubled pass from the filter, dimming and expansion rules and compares
*/
module tb_video_scan2x;

    localparam int HLEN   = 16;
    localparam int HSW    = 4;
    localparam int CW     = video_pkg::COLORW;
    localparam int HS_IN  = 2;
    localparam int NROWS  = 6;
    localparam int LPT    = 4;
    // Table lines, one extra line follows to show the last of them
    localparam int NL     = NROWS * LPT;
    localparam int NPASS  = 2 * (NL + 1);
    localparam int LIMIT  = NROWS * LPT * HLEN * 4 + 400;

    typedef struct packed {
        logic                bw_en;
        video_pkg::sl_mode_e sl;
        logic [15:0]         seed_ofs;
    } test_row_t;

    typedef struct packed {
        logic [CW-1:0] r;
        logic [CW-1:0] g;
        logic [CW-1:0] b;
    } game_rgb_t;

    logic                clk_sys;
    logic                arst_n;
    logic                pxl_cen;
    logic                pxl2_cen;
    logic                bw_en;
    logic                hs;
    logic                vs;
    logic                lhbl;
    logic                lvbl;
    video_pkg::sl_mode_e sl_mode;
    game_rgb_t           game;
    video_pkg::rgb8_t    scan2x_rgb;
    logic                scan2x_hs;
    logic                scan2x_de;
    logic                scan2x_cen;

    test_row_t rows [NROWS];
    game_rgb_t line_pix [0:NL][0:HLEN-1];
    int        line_row [0:NL];
    logic      line_first [0:NL];
    int        test_err [NROWS];

    integer     seed;
    int         cycles    = 0;
    int         pass_cnt  = 0;
    int         de_cnt    = 0;
    int         hs_cnt    = 0;
    int         check_cnt = 0;
    int         err_cnt   = 0;
    int         reset_err = 0;
    logic       pre_line  = 1'b1;
    logic [1:0] cen_hist  = 2'b00;

    tb_clk_gen u_clk (
        .clk    ( clk_sys ),
        .arst_n ( arst_n  )
    );

    video_scan2x_top #(.COLORW(CW), .HLEN(HLEN), .HSW(HSW)) UUT (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .pxl2_cen   ( pxl2_cen   ),
        .bw_en      ( bw_en      ),
        .sl_mode    ( sl_mode    ),
        .game_r     ( game.r     ),
        .game_g     ( game.g     ),
        .game_b     ( game.b     ),
        .hs         ( hs         ),
        .vs         ( vs         ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       ),
        .scan2x_rgb ( scan2x_rgb ),
        .scan2x_hs  ( scan2x_hs  ),
        .scan2x_de  ( scan2x_de  ),
        .scan2x_cen ( scan2x_cen )
    );

    task automatic fill_table();
        rows[0] = '{bw_en: 1'b0, sl: video_pkg::SL_NONE, seed_ofs: 16'h0000};
        rows[1] = '{bw_en: 1'b1, sl: video_pkg::SL_NONE, seed_ofs: 16'h0101};
        rows[2] = '{bw_en: 1'b0, sl: video_pkg::SL_50,   seed_ofs: 16'h0202};
        rows[3] = '{bw_en: 1'b1, sl: video_pkg::SL_25,   seed_ofs: 16'h0303};
        rows[4] = '{bw_en: 1'b0, sl: video_pkg::SL_75,   seed_ofs: 16'h0404};
        rows[5] = '{bw_en: 1'b1, sl: video_pkg::SL_50,   seed_ofs: 16'h0505};
    endtask

    function automatic game_rgb_t random_pixel();
        logic [31:0] rnd;
        rnd = $random(seed);
        return game_rgb_t'(rnd[3*CW-1:0]);
    endfunction

    // One game pixel takes 4 clocks, the doubled enable fires twice
    task automatic drive_pixel(input game_rgb_t px, input logic px_hs);
        @(posedge clk_sys);
        #1;
        game     = px;
        hs       = px_hs;
        lhbl     = !px_hs;
        pxl_cen  = 1'b1;
        pxl2_cen = 1'b1;
        @(posedge clk_sys);
        #1;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        @(posedge clk_sys);
        #1;
        pxl2_cen = 1'b1;
        @(posedge clk_sys);
        #1;
        pxl2_cen = 1'b0;
    endtask

    task automatic drive_line(input int ln, input test_row_t row);
        game_rgb_t px;
        for (int x = 0; x < HLEN; x++) begin
            px = random_pixel();
            line_pix[ln][x] = px;
            if (x == 0) begin
                bw_en = row.bw_en;
            end
            // Last doubled pixel of the previous line is still in flight at pixel 0
            if (x == 1) begin
                sl_mode = row.sl;
            end
            drive_pixel(px, x < HS_IN);
        end
    endtask

    function automatic logic [CW:0] add_pair(input logic [CW-1:0] a, input logic [CW-1:0] b);
        return {1'b0, a} + {1'b0, b};
    endfunction

    function automatic logic [CW:0] shade(input logic [CW:0] v, input video_pkg::sl_mode_e m);
        case (m)
            video_pkg::SL_25: return v - (v >> 2);
            video_pkg::SL_50: return v >> 1;
            video_pkg::SL_75: return v >> 2;
            default:          return v;
        endcase
    endfunction

    // Upper bits fill the low end of the byte
    function automatic logic [7:0] expand_chan(input logic [CW:0] v);
        logic [2*CW+1:0] two;
        two = {v, v};
        return two[2*CW+1 -: 8];
    endfunction

    function automatic video_pkg::rgb8_t expected_pixel(input int n, input int x,
                                                        input logic second,
                                                        input test_row_t row);
        game_rgb_t           cur;
        game_rgb_t           prv;
        video_pkg::sl_mode_e m;
        video_pkg::rgb8_t    e;
        cur = line_pix[n][x];
        if (x > 0) begin
            prv = line_pix[n][x-1];
        end else if (n > 0) begin
            prv = line_pix[n-1][HLEN-1];
        end else begin
            prv = '0;
        end
        if (!row.bw_en) begin
            prv = cur;
        end
        m   = second ? row.sl : video_pkg::SL_NONE;
        e.r = expand_chan(shade(add_pair(cur.r, prv.r), m));
        e.g = expand_chan(shade(add_pair(cur.g, prv.g), m));
        e.b = expand_chan(shade(add_pair(cur.b, prv.b), m));
        return e;
    endfunction

    // Shown line d holds input line d-1, skipped right after a settings change
    function automatic logic checked_line(input int d);
        return d >= 1 && d < NL && !line_first[d];
    endfunction

    task automatic count_error(input int p);
        err_cnt++;
        if (checked_line(p / 2)) begin
            test_err[line_row[p / 2]]++;
        end
    endtask

    task automatic check_pixel(input int p, input int x, input video_pkg::rgb8_t got);
        int               d;
        video_pkg::rgb8_t exp;
        d = p / 2;
        if (checked_line(d)) begin
            exp = expected_pixel(d - 1, x, p % 2 == 1, rows[line_row[d]]);
            check_cnt++;
            assert (got == exp) else begin
                $display("ERR %0t: line %0d pass %0d pixel %0d rgb %h, expected %h",
                         $time, d - 1, p % 2, x, got, exp);
                count_error(p);
            end
        end
    endtask

    task automatic report_test(input int t);
        video_pkg::sl_mode_e m;
        m = rows[t].sl;
        if (test_err[t] == 0) begin
            $display("test %0d bw_en=%0b sl_mode=%s: ok", t, rows[t].bw_en, m.name());
        end else begin
            $display("test %0d bw_en=%0b sl_mode=%s: %0d errors", t, rows[t].bw_en,
                     m.name(), test_err[t]);
        end
    endtask

    task automatic close_pass(input int p);
        int d;
        d = p / 2;
        if (p % 2 == 1 && d < NL && d % LPT == LPT - 1) begin
            report_test(line_row[d]);
        end
    endtask

    // Outputs settle after the rising edge, sample them on the falling one
    always @(negedge clk_sys) begin
        // scan2x_cen trails pxl2_cen by two clocks
        if (arst_n) begin
            assert (scan2x_cen == cen_hist[1]) else begin
                $display("ERR %0t: scan2x_cen %0b, expected %0b",
                         $time, scan2x_cen, cen_hist[1]);
                count_error(pass_cnt);
            end
        end
        cen_hist = {cen_hist[0], pxl2_cen};
        if (arst_n && pre_line) begin
            assert (!scan2x_hs && !scan2x_de && scan2x_rgb == '0) else begin
                $display("ERR %0t: output active before the first line start", $time);
                reset_err++;
                err_cnt++;
            end
        end
        if (scan2x_cen) begin
            if (scan2x_hs) begin
                assert (de_cnt == 0) else begin
                    $display("ERR %0t: sync inside the data run of pass %0d", $time, pass_cnt);
                    count_error(pass_cnt);
                end
                hs_cnt++;
            end else if (scan2x_de) begin
                if (de_cnt == 0) begin
                    assert (hs_cnt == HSW) else begin
                        $display("ERR %0t: pass %0d began after %0d sync pixels",
                                 $time, pass_cnt, hs_cnt);
                        count_error(pass_cnt);
                    end
                    hs_cnt = 0;
                end
                check_pixel(pass_cnt, HSW + de_cnt, scan2x_rgb);
                de_cnt++;
                if (de_cnt == HLEN - HSW) begin
                    close_pass(pass_cnt);
                    de_cnt = 0;
                    pass_cnt++;
                end
            end else begin
                assert (de_cnt == 0) else begin
                    $display("ERR %0t: data run of pass %0d broken", $time, pass_cnt);
                    count_error(pass_cnt);
                end
            end
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d passes seen",
                     LIMIT, pass_cnt, NPASS);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int clean;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        bw_en    = 1'b0;
        sl_mode  = video_pkg::SL_NONE;
        game     = '0;
        hs       = 1'b0;
        vs       = 1'b0;
        lhbl     = 1'b1;
        lvbl     = 1'b1;
        seed     = 32'hbef731ec;
        for (int t = 0; t < NROWS; t++) begin
            test_err[t] = 0;
        end
        fill_table();
        @(posedge arst_n);

        // Enables run a while before the first line start
        for (int i = 0; i < 4; i++) begin
            drive_pixel(random_pixel(), 1'b0);
        end
        pre_line = 1'b0;
        if (reset_err == 0) begin
            $display("reset idle: ok");
        end else begin
            $display("reset idle: %0d errors", reset_err);
        end

        for (int t = 0; t < NROWS; t++) begin
            seed = 32'hbef731ec + rows[t].seed_ofs;
            for (int l = 0; l < LPT; l++) begin
                line_row[t*LPT + l]   = t;
                line_first[t*LPT + l] = (l == 0);
                drive_line(t*LPT + l, rows[t]);
            end
        end
        line_row[NL]   = NROWS - 1;
        line_first[NL] = 1'b0;
        drive_line(NL, rows[NROWS-1]);
        while (pass_cnt < NPASS) begin
            drive_pixel(random_pixel(), 1'b0);
        end

        clean = 0;
        for (int t = 0; t < NROWS; t++) begin
            if (test_err[t] == 0) begin
                clean++;
            end
        end
        $display("summary: %0d pixel checks, %0d errors, %0d of %0d tests clean",
                 check_cnt, err_cnt, clean, NROWS);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
